//--- source/isa_pkg.sv
// integer ISA of the simple ALU lane: word and immediate widths, shift amount, opcodes
`default_nettype none

package isa_pkg;

	localparam int unsigned DATA_WIDTH  = 32;  // architectural word
	localparam int unsigned IMM_WIDTH   = 16;  // instruction immediate
	localparam int unsigned SHAMT_WIDTH = $clog2(DATA_WIDTH);
	localparam int unsigned NUM_OPS     = 29;  // opcodes are dense from zero

	typedef logic [DATA_WIDTH-1:0]  data_t;
	typedef logic [IMM_WIDTH-1:0]   imm_t;
	typedef logic [SHAMT_WIDTH-1:0] shamt_t;

	typedef enum logic [5:0] {
		OP_ADD = 6'd0,
		OP_ADDI,
		OP_ADDU,
		OP_ADDIU,
		OP_SUB,
		OP_SUBU,
		OP_MFHI,
		OP_MTHI,
		OP_MFLO,
		OP_MTLO,
		OP_AND,
		OP_ANDI,
		OP_OR,
		OP_ORI,
		OP_XOR,
		OP_XORI,
		OP_NOR,
		OP_SLL,
		OP_SLLV,
		OP_SRL,
		OP_SRLV,
		OP_SRA,
		OP_SRAV,
		OP_SLT,
		OP_SLTI,
		OP_SLTU,
		OP_SLTIU,
		OP_LUI,
		OP_NOP    // last member, NUM_OPS-1
	} alu_op_e;

endpackage

`default_nettype wire

//--- source/exec_pkg.sv
// execution flag layout produced by the ALU and registered at writeback
`default_nettype none

package exec_pkg;

	localparam int unsigned EXEC_FLAGS = 6;

	// bit positions inside exec_flags_t
	localparam int unsigned FLAG_MISPRED = 0;  // never set, no branches here
	localparam int unsigned FLAG_EXCEPT  = 1;  // signed overflow
	localparam int unsigned FLAG_EXEC    = 2;
	localparam int unsigned FLAG_MEM     = 3;  // never set, no loads or stores
	localparam int unsigned FLAG_DEST    = 4;  // result goes to a register
	localparam int unsigned FLAG_CTRL    = 5;  // never set

	typedef logic [EXEC_FLAGS-1:0] exec_flags_t;

endpackage

`default_nettype wire

//--- source/payload_if.sv
// registered instruction payload from the operand stage to the ALU
`timescale 1ns/1ps
`default_nettype none

interface payload_if #(
	parameter int unsigned TAG_WIDTH = 6
);
	import isa_pkg::*;

	logic                 valid;
	alu_op_e              op;
	data_t                src_a;
	data_t                src_b;  // extended immediate or data2
	shamt_t               shamt;
	logic [TAG_WIDTH-1:0] tag;

	modport src_mp (output valid, op, src_a, src_b, shamt, tag);
	modport alu_mp (input valid, op, src_a, src_b, shamt, tag);

endinterface

`default_nettype wire

//--- source/result_if.sv
// ALU result, flags and HI/LO write enables headed for writeback
`timescale 1ns/1ps
`default_nettype none

interface result_if #(
	parameter int unsigned TAG_WIDTH = 6
);
	import isa_pkg::*;
	import exec_pkg::*;

	logic                 valid;
	data_t                result;
	exec_flags_t          flags;
	logic [TAG_WIDTH-1:0] tag;
	logic                 hi_we;  // MTHI
	logic                 lo_we;  // MTLO

	modport alu_mp (output valid, result, flags, tag, hi_we, lo_we);
	modport wb_mp  (input valid, result, flags, tag, hi_we, lo_we);

endinterface

`default_nettype wire

//--- source/operand_stage.sv
// issue register: extends the immediate and picks operand B and the shift amount
`timescale 1ns/1ps
`default_nettype none

module operand_stage #(
	parameter int unsigned TAG_WIDTH = 6
) (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 valid_i,
	input  isa_pkg::alu_op_e     op_i,
	input  isa_pkg::data_t       data1_i,
	input  isa_pkg::data_t       data2_i,
	input  isa_pkg::imm_t        immd_i,
	input  logic [TAG_WIDTH-1:0] tag_i,
	payload_if.src_mp            payload
);
	import isa_pkg::*;

	localparam int unsigned EXT_WIDTH = DATA_WIDTH - IMM_WIDTH;

	data_t  imm_sext;
	data_t  imm_zext;
	data_t  src_a_d;
	data_t  src_b_d;
	shamt_t shamt_d;

	assign imm_sext = {{EXT_WIDTH{immd_i[IMM_WIDTH-1]}}, immd_i};
	assign imm_zext = {{EXT_WIDTH{1'b0}}, immd_i};

	always_comb
	begin
		src_a_d = data1_i;
		src_b_d = data2_i;
		shamt_d = immd_i[SHAMT_WIDTH-1:0];  // constant shift forms
		case (op_i)
			OP_ADDI, OP_ADDIU, OP_SLTI:
				src_b_d = imm_sext;
			OP_ANDI, OP_ORI, OP_XORI, OP_SLTIU:
				src_b_d = imm_zext;
			OP_SLLV, OP_SRLV, OP_SRAV:
			begin
				src_a_d = data2_i;  // value to shift is rt
				shamt_d = data1_i[SHAMT_WIDTH-1:0];
			end
			OP_LUI:
				src_b_d = {immd_i, {EXT_WIDTH{1'b0}}};
			default:
				src_b_d = data2_i;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			payload.valid <= 1'b0;
		else
			payload.valid <= valid_i;
	end

	always_ff @(posedge clk)
	begin
		payload.op    <= op_i;
		payload.src_a <= src_a_d;
		payload.src_b <= src_b_d;
		payload.shamt <= shamt_d;
		payload.tag   <= tag_i;
	end

	// issue logic must never send an opcode outside the defined set
	a_issue_op_defined: assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_i |-> (int'(op_i) < int'(NUM_OPS)))
		else $error("operand_stage: undefined opcode %0h issued", op_i);

endmodule

`default_nettype wire

//--- source/simple_alu.sv
// combinational integer ALU: result and execution flags for each opcode
`timescale 1ns/1ps
`default_nettype none

module simple_alu (
	payload_if.alu_mp      payload,
	input  isa_pkg::data_t hi_i,
	input  isa_pkg::data_t lo_i,
	result_if.alu_mp       res
);
	import isa_pkg::*;
	import exec_pkg::*;

	localparam int unsigned MSB = DATA_WIDTH - 1;

	data_t       sum;
	data_t       diff;
	logic        add_ovf;
	logic        sub_ovf;
	logic        lt_signed;
	logic        lt_unsigned;
	data_t       result;
	exec_flags_t flags;
	logic        hi_we;
	logic        lo_we;

	assign sum  = payload.src_a + payload.src_b;
	assign diff = payload.src_a - payload.src_b;

	// same-sign operands whose sum flips sign
	assign add_ovf = (payload.src_a[MSB] == payload.src_b[MSB]) &&
		(sum[MSB] != payload.src_a[MSB]);
	// opposite-sign operands, difference takes the sign of b
	assign sub_ovf = (payload.src_a[MSB] != payload.src_b[MSB]) &&
		(diff[MSB] != payload.src_a[MSB]);

	assign lt_signed   = $signed(payload.src_a) < $signed(payload.src_b);
	assign lt_unsigned = payload.src_a < payload.src_b;

	always_comb
	begin
		result = '0;
		hi_we  = 1'b0;
		lo_we  = 1'b0;
		flags[FLAG_MISPRED] = 1'b0;
		flags[FLAG_EXCEPT]  = 1'b0;
		flags[FLAG_EXEC]    = 1'b1;
		flags[FLAG_MEM]     = 1'b0;
		flags[FLAG_DEST]    = 1'b1;
		flags[FLAG_CTRL]    = 1'b0;
		case (payload.op)
			OP_ADD, OP_ADDI:
			begin
				result             = sum;
				flags[FLAG_EXCEPT] = add_ovf;
			end
			OP_ADDU, OP_ADDIU:
				result = sum;  // unsigned forms never trap
			OP_SUB:
			begin
				result             = diff;
				flags[FLAG_EXCEPT] = sub_ovf;
			end
			OP_SUBU:
				result = diff;
			OP_MFHI:
				result = hi_i;
			OP_MFLO:
				result = lo_i;
			OP_MTHI:
			begin
				result           = payload.src_a;
				hi_we            = 1'b1;
				flags[FLAG_DEST] = 1'b0;  // writes HI, not the register file
			end
			OP_MTLO:
			begin
				result           = payload.src_a;
				lo_we            = 1'b1;
				flags[FLAG_DEST] = 1'b0;
			end
			OP_AND, OP_ANDI:
				result = payload.src_a & payload.src_b;
			OP_OR, OP_ORI:
				result = payload.src_a | payload.src_b;
			OP_XOR, OP_XORI:
				result = payload.src_a ^ payload.src_b;
			OP_NOR:
				result = ~(payload.src_a | payload.src_b);
			OP_SLL, OP_SLLV:
				result = payload.src_a << payload.shamt;
			OP_SRL, OP_SRLV:
				result = payload.src_a >> payload.shamt;
			OP_SRA, OP_SRAV:
				result = $signed(payload.src_a) >>> payload.shamt;
			OP_SLT, OP_SLTI:
				result = data_t'(lt_signed);
			OP_SLTU, OP_SLTIU:
				result = data_t'(lt_unsigned);
			OP_LUI:
				result = payload.src_b;  // immediate already in the upper half
			OP_NOP:
				flags[FLAG_DEST] = 1'b0;
			default:
				flags = '0;  // undefined opcode, nothing executed
		endcase
	end

	assign res.valid  = payload.valid;
	assign res.result = result;
	assign res.flags  = flags;
	assign res.tag    = payload.tag;
	assign res.hi_we  = hi_we;
	assign res.lo_we  = lo_we;

	// a registered instruction must decode to a defined opcode
	always_comb
	begin
		if (payload.valid)
			a_valid_executed: assert final (flags[FLAG_EXEC] && !flags[FLAG_MISPRED])
				else $error("simple_alu: bad flags %0h for op %0h", flags, payload.op);
	end

endmodule

`default_nettype wire

//--- source/writeback_stage.sv
// writeback register for result, flags and tag, plus the HI and LO registers
`timescale 1ns/1ps
`default_nettype none

module writeback_stage #(
	parameter int unsigned TAG_WIDTH = 6
) (
	input  logic                  clk,
	input  logic                  rst_n_i,
	result_if.wb_mp               res,
	output isa_pkg::data_t        hi_o,
	output isa_pkg::data_t        lo_o,
	output logic                  wb_valid_o,
	output isa_pkg::data_t        wb_result_o,
	output exec_pkg::exec_flags_t wb_flags_o,
	output logic [TAG_WIDTH-1:0]  wb_tag_o
);
	import exec_pkg::*;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			wb_valid_o  <= 1'b0;
			wb_result_o <= '0;
			wb_flags_o  <= '0;
			wb_tag_o    <= '0;
		end
		else
		begin
			wb_valid_o <= res.valid;
			if (res.valid)
			begin
				wb_result_o <= res.result;
				wb_flags_o  <= res.flags;
				wb_tag_o    <= res.tag;
			end
		end
	end

	// HI/LO written on the same edge as the result, so the next MF sees it
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			hi_o <= '0;
			lo_o <= '0;
		end
		else
		begin
			if (res.valid && res.hi_we)
				hi_o <= res.result;
			if (res.valid && res.lo_we)
				lo_o <= res.result;
		end
	end

	// only MTHI or MTLO write HI/LO, one at a time and never the register file
	a_hilo_write_no_dest: assert property (@(posedge clk) disable iff (!rst_n_i)
		(res.valid && (res.hi_we || res.lo_we)) |->
			(!(res.hi_we && res.lo_we) && !res.flags[FLAG_DEST]))
		else $error("writeback_stage: HI/LO write with flags %0h", res.flags);

endmodule

`default_nettype wire

//--- source/simple_exec_top.sv
// integer execution lane: operand stage, ALU and writeback stage
`timescale 1ns/1ps
`default_nettype none

module simple_exec_top #(
	parameter int unsigned TAG_WIDTH = 6
) (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  issue_valid_i,
	input  isa_pkg::alu_op_e      issue_op_i,
	input  isa_pkg::data_t        issue_data1_i,
	input  isa_pkg::data_t        issue_data2_i,
	input  isa_pkg::imm_t         issue_immd_i,
	input  logic [TAG_WIDTH-1:0]  issue_tag_i,
	output logic                  wb_valid_o,
	output isa_pkg::data_t        wb_result_o,
	output exec_pkg::exec_flags_t wb_flags_o,
	output logic [TAG_WIDTH-1:0]  wb_tag_o
);
	import isa_pkg::*;

	data_t hi;  // architectural HI, read by MFHI
	data_t lo;

	payload_if #(.TAG_WIDTH(TAG_WIDTH)) payload_bus ();
	result_if  #(.TAG_WIDTH(TAG_WIDTH)) result_bus ();

	operand_stage #(.TAG_WIDTH(TAG_WIDTH)) operand_stage_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.valid_i (issue_valid_i),
		.op_i    (issue_op_i),
		.data1_i (issue_data1_i),
		.data2_i (issue_data2_i),
		.immd_i  (issue_immd_i),
		.tag_i   (issue_tag_i),
		.payload (payload_bus.src_mp)
	);

	simple_alu simple_alu_inst (
		.payload (payload_bus.alu_mp),
		.hi_i    (hi),
		.lo_i    (lo),
		.res     (result_bus.alu_mp)
	);

	writeback_stage #(.TAG_WIDTH(TAG_WIDTH)) writeback_stage_inst (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.res         (result_bus.wb_mp),
		.hi_o        (hi),
		.lo_o        (lo),
		.wb_valid_o  (wb_valid_o),
		.wb_result_o (wb_result_o),
		.wb_flags_o  (wb_flags_o),
		.wb_tag_o    (wb_tag_o)
	);

endmodule

`default_nettype wire

//--- bench/alu_model.svh
// reference model of the ALU lane: expected result and flags per opcode, with its own HI/LO copy
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

data_t model_hi = '0;  // follows issue order
data_t model_lo = '0;

// true when the exact sum or difference does not fit in a signed word
function automatic logic overflows(input data_t a, input data_t b, input logic is_sub);
	longint wide;
	if (is_sub)
		wide = longint'($signed(a)) - longint'($signed(b));
	else
		wide = longint'($signed(a)) + longint'($signed(b));
	return wide != longint'($signed(wide[31:0]));
endfunction

task automatic model_execute(input alu_op_e op, input data_t d1, input data_t d2,
	input imm_t immd, output data_t result, output exec_flags_t flags);
	data_t simm;
	data_t zimm;
	simm = {{16{immd[15]}}, immd};
	zimm = {16'h0000, immd};
	result = '0;
	flags = '0;
	flags[FLAG_EXEC] = 1'b1;
	flags[FLAG_DEST] = 1'b1;
	case (op)
		OP_ADD:
		begin
			result = d1 + d2;
			flags[FLAG_EXCEPT] = overflows(d1, d2, 1'b0);
		end
		OP_ADDI:
		begin
			result = d1 + simm;
			flags[FLAG_EXCEPT] = overflows(d1, simm, 1'b0);
		end
		OP_ADDU:  result = d1 + d2;
		OP_ADDIU: result = d1 + simm;  // no trap on the unsigned forms
		OP_SUB:
		begin
			result = d1 - d2;
			flags[FLAG_EXCEPT] = overflows(d1, d2, 1'b1);
		end
		OP_SUBU:  result = d1 - d2;
		OP_MFHI:  result = model_hi;
		OP_MFLO:  result = model_lo;
		OP_MTHI:
		begin
			result = d1;
			model_hi = d1;
			flags[FLAG_DEST] = 1'b0;
		end
		OP_MTLO:
		begin
			result = d1;
			model_lo = d1;
			flags[FLAG_DEST] = 1'b0;
		end
		OP_AND:   result = d1 & d2;
		OP_ANDI:  result = d1 & zimm;
		OP_OR:    result = d1 | d2;
		OP_ORI:   result = d1 | zimm;
		OP_XOR:   result = d1 ^ d2;
		OP_XORI:  result = d1 ^ zimm;
		OP_NOR:   result = ~(d1 | d2);
		OP_SLL:   result = d1 << immd[4:0];
		OP_SLLV:  result = d2 << d1[4:0];  // variable forms shift rt by rs
		OP_SRL:   result = d1 >> immd[4:0];
		OP_SRLV:  result = d2 >> d1[4:0];
		OP_SRA:   result = $signed(d1) >>> immd[4:0];
		OP_SRAV:  result = $signed(d2) >>> d1[4:0];
		OP_SLT:   result = ($signed(d1) < $signed(d2)) ? 32'd1 : 32'd0;
		OP_SLTI:  result = ($signed(d1) < $signed(simm)) ? 32'd1 : 32'd0;
		OP_SLTU:  result = (d1 < d2) ? 32'd1 : 32'd0;
		OP_SLTIU: result = (d1 < zimm) ? 32'd1 : 32'd0;
		OP_LUI:   result = {immd, 16'h0000};
		OP_NOP:   flags[FLAG_DEST] = 1'b0;
		default:  flags = '0;
	endcase
endtask

`endif

//--- bench/simple_exec_tb.sv
// testbench for the integer execution lane: random issue checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module simple_exec_tb;
	import isa_pkg::*;
	import exec_pkg::*;

	localparam int unsigned TAG_WIDTH = 6;
	localparam alu_op_e ARITH_OPS [6] = '{OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU, OP_SUB, OP_SUBU};
	localparam alu_op_e LOGIC_OPS [18] = '{OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI,
		OP_NOR, OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV, OP_SLT, OP_SLTI, OP_SLTU,
		OP_SLTIU, OP_LUI};
	localparam alu_op_e HILO_OPS [4] = '{OP_MTHI, OP_MTLO, OP_MFHI, OP_MFLO};

	logic                 clk = 1'b0;
	logic                 rst_n_i;
	logic                 issue_valid_i;
	alu_op_e              issue_op_i;
	data_t                issue_data1_i;
	data_t                issue_data2_i;
	imm_t                 issue_immd_i;
	logic [TAG_WIDTH-1:0] issue_tag_i;
	logic                 wb_valid_o;
	data_t                wb_result_o;
	exec_flags_t          wb_flags_o;
	logic [TAG_WIDTH-1:0] wb_tag_o;

	data_t                exp_result_q[$];  // one entry per issued instruction
	exec_flags_t          exp_flags_q[$];
	logic [TAG_WIDTH-1:0] exp_tag_q[$];
	int unsigned          exp_due_q[$];  // cycle where wb_valid_o must show it
	int unsigned          cycle_count = 0;
	int unsigned          wait_cycles;

	`include "alu_model.svh"

	simple_exec_top #(.TAG_WIDTH(TAG_WIDTH)) simple_exec_inst (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.issue_valid_i (issue_valid_i),
		.issue_op_i    (issue_op_i),
		.issue_data1_i (issue_data1_i),
		.issue_data2_i (issue_data2_i),
		.issue_immd_i  (issue_immd_i),
		.issue_tag_i   (issue_tag_i),
		.wb_valid_o    (wb_valid_o),
		.wb_result_o   (wb_result_o),
		.wb_flags_o    (wb_flags_o),
		.wb_tag_o      (wb_tag_o)
	);

	always #5 clk = ~clk;

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	function automatic data_t edge_word();
		case ($urandom_range(0, 5))
			0: return 32'h7fff_ffff;
			1: return 32'h8000_0000;
			2: return 32'h7fff_ffff - data_t'($urandom_range(0, 15));
			3: return 32'h8000_0000 + data_t'($urandom_range(0, 15));
			4: return 32'hffff_ffff;
			default: return $urandom();
		endcase
	endfunction

	function automatic imm_t edge_imm();
		case ($urandom_range(0, 4))
			0: return 16'h7fff;
			1: return 16'h8000;  // most negative immediate
			2: return 16'hffff;
			3: return 16'h0001;
			default: return 16'($urandom());
		endcase
	endfunction

	task automatic issue_one(input alu_op_e op, input data_t d1, input data_t d2, input imm_t immd);
		data_t                exp_result;
		exec_flags_t          exp_flags;
		logic [TAG_WIDTH-1:0] tag;
		tag = TAG_WIDTH'($urandom());
		@(negedge clk);
		issue_valid_i = 1'b1;
		issue_op_i    = op;
		issue_data1_i = d1;
		issue_data2_i = d2;
		issue_immd_i  = immd;
		issue_tag_i   = tag;
		model_execute(op, d1, d2, immd, exp_result, exp_flags);
		exp_result_q.push_back(exp_result);
		exp_flags_q.push_back(exp_flags);
		exp_tag_q.push_back(tag);
		exp_due_q.push_back(cycle_count + 2);
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		issue_valid_i = 1'b0;
		issue_data1_i = $urandom();  // junk while idle
	endtask

	// each cycle issues with probability 3/4
	task automatic maybe_idle();
		while ($urandom_range(0, 3) == 0)
			idle_cycle();
	endtask

	always @(posedge clk)
	begin
		data_t                exp_result;
		exec_flags_t          exp_flags;
		logic [TAG_WIDTH-1:0] exp_tag;
		int unsigned          exp_due;
		if (rst_n_i && wb_valid_o)
		begin
			assert (exp_due_q.size() != 0)
				else abort_run("wb_valid_o was high with no instruction in flight");
			exp_result = exp_result_q.pop_front();
			exp_flags  = exp_flags_q.pop_front();
			exp_tag    = exp_tag_q.pop_front();
			exp_due    = exp_due_q.pop_front();
			assert (exp_due == cycle_count)
				else abort_run($sformatf("error: wb_valid_o at cycle %0h, expected cycle %0h",
					cycle_count, exp_due));
			assert (wb_tag_o == exp_tag)
				else abort_run($sformatf("error: wb_tag_o got %02h, expected %02h",
					wb_tag_o, exp_tag));
			assert (wb_result_o == exp_result)
				else abort_run($sformatf("error: wb_result_o got %08h, expected %08h",
					wb_result_o, exp_result));
			assert (wb_flags_o == exp_flags)
				else abort_run($sformatf("error: wb_flags_o got %02h, expected %02h",
					wb_flags_o, exp_flags));
		end
		else if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle_count)
			abort_run("an issued instruction did not reach writeback two cycles later");
		cycle_count++;
	end

	initial
	begin
		void'($urandom(32'h9f7b));
		rst_n_i       = 1'b0;
		issue_valid_i = 1'b0;
		issue_op_i    = OP_NOP;
		issue_data1_i = '0;
		issue_data2_i = '0;
		issue_immd_i  = '0;
		issue_tag_i   = '0;
		repeat (3) @(negedge clk);
		rst_n_i = 1'b1;

		repeat (10)
		begin
			@(negedge clk);
			assert (wb_valid_o == 1'b0)
				else abort_run($sformatf("error: wb_valid_o is %0h while idle, expected 0",
					wb_valid_o));
		end

		// back to back stream, then the default 3/4 issue rate
		repeat (200)
			issue_one(alu_op_e'(6'($urandom_range(0, NUM_OPS - 1))), $urandom(), $urandom(),
				16'($urandom()));
		repeat (200)
		begin
			maybe_idle();
			issue_one(alu_op_e'(6'($urandom_range(0, NUM_OPS - 1))), $urandom(), $urandom(),
				16'($urandom()));
		end

		repeat (300)
		begin
			maybe_idle();
			issue_one(ARITH_OPS[$urandom_range(0, 5)], edge_word(), edge_word(), edge_imm());
		end

		repeat (300)
		begin
			maybe_idle();
			issue_one(LOGIC_OPS[$urandom_range(0, 17)], edge_word(), edge_word(), edge_imm());
		end

		repeat (200)
		begin
			maybe_idle();
			issue_one(HILO_OPS[$urandom_range(0, 3)], $urandom(), $urandom(), 16'($urandom()));
		end

		repeat (20)
			issue_one(OP_NOP, $urandom(), $urandom(), 16'($urandom()));

		idle_cycle();
		for (wait_cycles = 0; wait_cycles < 20 && exp_due_q.size() != 0; wait_cycles++)
			@(negedge clk);
		if (exp_due_q.size() == 0)
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
			abort_run("writeback queue did not drain within 20 cycles");
	end

endmodule

`default_nettype wire

//--- simple_exec.f
+incdir+bench
source/isa_pkg.sv
source/exec_pkg.sv
source/payload_if.sv
source/result_if.sv
source/operand_stage.sv
source/simple_alu.sv
source/writeback_stage.sv
source/simple_exec_top.sv
bench/simple_exec_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
	--top-module simple_exec_tb \
	-Mdir obj_dir \
	-f simple_exec.f
./obj_dir/Vsimple_exec_tb
